// File: hw/board_ctrl_pkg.sv
package board_ctrl_pkg;

	// GPIO lines on the board header
	localparam int GPIO_CNT = 8;

	typedef logic [GPIO_CNT-1:0] gpio_t;

	// Reset hold time is 2^width - 1 cycles of clk_4x_w
	localparam int RST_CNT_W_DFLT = 20;

	// Dimming counter for the activity indicator
	localparam int ACT_CNT_W = 1;

	// Software reset command, bit 0 is rst0 and bit 1 is rst1
	//   2'b11 cold reset
	//   2'b10 warm reset
	//   2'b01 power-off
	//   2'b00 no command
	typedef logic [1:0] swrst_cmd_t;

	// Bus slave indices
	localparam int DEV_CNT = 10;

	typedef logic [$clog2(DEV_CNT)-1:0] dev_idx_t;

	localparam dev_idx_t DEV_SDCARD  = 4'd0;
	localparam dev_idx_t DEV_DEVTBL  = 4'd1;
	localparam dev_idx_t DEV_GPIO    = 4'd2;
	localparam dev_idx_t DEV_INTCTRL = 4'd3;
	localparam dev_idx_t DEV_UART    = 4'd4;
	localparam dev_idx_t DEV_RAM     = 4'd5;
	localparam dev_idx_t DEV_RAMCTRL = 4'd6;
	localparam dev_idx_t DEV_BOOTLDR = 4'd7;
	localparam dev_idx_t DEV_FBDEV   = 4'd8;
	// Default slave that catches accesses outside the map
	localparam dev_idx_t DEV_INVALID = 4'd9;

	// Device-type ID reported by the device table
	typedef logic [7:0] dev_id_t;

	// Interrupt controller source lines
	localparam int INT_SRC_CNT = 3;

	typedef logic [$clog2(INT_SRC_CNT)-1:0] int_src_t;

	localparam int_src_t INT_SRC_SDCARD = 2'd0;
	localparam int_src_t INT_SRC_GPIO   = 2'd1;
	localparam int_src_t INT_SRC_UART   = 2'd2;

endpackage

// File: hw/rst_seq.sv
module rst_seq
	import board_ctrl_pkg::*;
#(
	parameter int RST_CNT_W = RST_CNT_W_DFLT
) (
	 input  logic       clk_4x_w
	,input  logic       rst_p

	,input  logic       pll_locked_i
	,input  logic       cpu_rst_req_i
	,input  swrst_cmd_t swrst_cmd_i

	,output logic       sys_rst_o
	,output logic       ram_rst_o
	,output logic       cold_rst_o
);

	logic swcold;
	logic swwarm;
	logic swpwroff;

	logic [RST_CNT_W-1:0] sys_cnt;
	logic [RST_CNT_W-1:0] ram_cnt;

	logic pwroff_r;

	logic sys_reload;

	// Software reset command decode
	assign swcold   = swrst_cmd_i[0] & swrst_cmd_i[1];
	assign swwarm   = ~swrst_cmd_i[0] & swrst_cmd_i[1];
	assign swpwroff = swrst_cmd_i[0] & ~swrst_cmd_i[1];

	// Any of these restarts the full hold time
	assign sys_reload = rst_p | cpu_rst_req_i | swwarm;

	// System reset counter
	// Reloads while a request is present, then counts down to zero
	always_ff @(posedge clk_4x_w) begin
		if (sys_reload) begin
			sys_cnt <= '1;
		end else if (sys_cnt != '0) begin
			sys_cnt <= sys_cnt - 1'b1;
		end
	end

	// Power-off latch
	// Only the external reset brings the board back
	always_ff @(posedge clk_4x_w) begin
		if (swpwroff) begin
			pwroff_r <= 1'b1;
		end else if (rst_p) begin
			pwroff_r <= 1'b0;
		end
	end

	// Memory reset counter
	// Ignores software and processor requests so the memory
	// contents survive a warm reset
	always_ff @(posedge clk_4x_w) begin
		if (rst_p) begin
			ram_cnt <= '1;
		end else if (pll_locked_i && (ram_cnt != '0)) begin
			ram_cnt <= ram_cnt - 1'b1;
		end
	end

	// PLL loss takes effect in the same cycle
	assign sys_rst_o = (|sys_cnt) | pwroff_r | ~pll_locked_i;

	assign ram_rst_o = |ram_cnt;

	assign cold_rst_o = swcold;

endmodule

// File: hw/activity_led.sv
module activity_led
	import board_ctrl_pkg::*;
(
	 input  logic  clk_4x_w
	,input  logic  rst_p

	,input  logic  sd_di_i
	,input  logic  sd_do_i
	,input  logic  dram_err_i

	,input  gpio_t gpio_i
	,output gpio_t gp_o
);

	logic                 act_trig;
	logic                 act_r;
	logic [ACT_CNT_W-1:0] act_cnt;

	// SD lines idle high, so a low on either one is bus traffic
	assign act_trig = ~(sd_di_i & sd_do_i) | dram_err_i;

	// One pulse then a quiet gap of 2^ACT_CNT_W - 1 cycles
	// keeps the LED at reduced brightness under constant traffic
	always_ff @(posedge clk_4x_w) begin
		if (rst_p) begin
			act_r   <= 1'b0;
			act_cnt <= '0;
		end else if (act_cnt != '0) begin
			act_r   <= 1'b0;
			act_cnt <= act_cnt - 1'b1;
		end else if (act_trig) begin
			act_r   <= 1'b1;
			act_cnt <= '1;
		end else begin
			act_r   <= 1'b0;
		end
	end

	// Activity shares the LED on GPIO bit 0
	assign gp_o = gpio_i | {{(GPIO_CNT-1){1'b0}}, act_r};

endmodule

// File: hw/dev_table.sv
module dev_table
	import board_ctrl_pkg::*;
(
	 input  logic     clk_4x_w
	,input  logic     rst_p

	,input  logic     rd_stb_i
	,input  dev_idx_t rd_idx_i

	,output logic     rd_vld_o
	,output logic     rd_useintr_o
	,output dev_id_t  rd_id_o
	,output int_src_t rd_int_src_o
);

	dev_idx_t lkup_idx;
	dev_id_t  lkup_id;
	logic     lkup_useintr;
	int_src_t lkup_int_src;

	// Unmapped indices fall on the default slave
	assign lkup_idx = (rd_idx_i < DEV_CNT) ? rd_idx_i : DEV_INVALID;

	// Constant table of device ID, interrupt use and source line
	always_comb begin
		lkup_id      = 8'd0;
		lkup_useintr = 1'b0;
		lkup_int_src = '0;
		case (lkup_idx)
			DEV_SDCARD: begin
				lkup_id      = 8'd4;
				lkup_useintr = 1'b1;
				lkup_int_src = INT_SRC_SDCARD;
			end
			DEV_DEVTBL: begin
				lkup_id = 8'd7;
			end
			DEV_GPIO: begin
				lkup_id      = 8'd6;
				lkup_useintr = 1'b1;
				lkup_int_src = INT_SRC_GPIO;
			end
			DEV_INTCTRL: begin
				lkup_id = 8'd3;
			end
			DEV_UART: begin
				lkup_id      = 8'd5;
				lkup_useintr = 1'b1;
				lkup_int_src = INT_SRC_UART;
			end
			DEV_RAM: begin
				lkup_id = 8'd1;
			end
			DEV_RAMCTRL: begin
				lkup_id = 8'd0;
			end
			DEV_BOOTLDR: begin
				lkup_id = 8'd0;
			end
			DEV_FBDEV: begin
				lkup_id = 8'd10;
			end
			DEV_INVALID: begin
				lkup_id = 8'd0;
			end
			default: begin
				lkup_id = 8'd0;
			end
		endcase
	end

	// Reply strobe follows the request by one cycle
	always_ff @(posedge clk_4x_w) begin
		if (rst_p) begin
			rd_vld_o <= 1'b0;
		end else begin
			rd_vld_o <= rd_stb_i;
		end
	end

	// Reply data, held between requests
	always_ff @(posedge clk_4x_w) begin
		if (rd_stb_i) begin
			rd_id_o      <= lkup_id;
			rd_useintr_o <= lkup_useintr;
			rd_int_src_o <= lkup_int_src;
		end
	end

endmodule

// File: hw/board_ctrl_top.sv
module board_ctrl_top
	import board_ctrl_pkg::*;
#(
	parameter int RST_CNT_W = RST_CNT_W_DFLT
) (
	 input  logic       clk_4x_w
	,input  logic       rst_p

	// Status from the PLL and the processor
	,input  logic       pll_locked_i
	,input  logic       cpu_rst_req_i
	,input  swrst_cmd_t swrst_cmd_i

	// SD-card bus lines, DRAM init status and GPIO value
	,input  logic       sd_di_i
	,input  logic       sd_do_i
	,input  logic       dram_err_i
	,input  gpio_t      gpio_i

	// Device-table lookup request
	,input  logic       rd_stb_i
	,input  dev_idx_t   rd_idx_i

	// Reset outputs
	,output logic       sys_rst_o
	,output logic       ram_rst_o
	,output logic       cold_rst_o
	,output logic       sd_reset_o

	,output gpio_t      gp_o

	// Device-table lookup reply
	,output logic       rd_vld_o
	,output logic       rd_useintr_o
	,output dev_id_t    rd_id_o
	,output int_src_t   rd_int_src_o
);

	rst_seq #(
		.RST_CNT_W (RST_CNT_W)
	) u_rst_seq (
		 .clk_4x_w      (clk_4x_w)
		,.rst_p         (rst_p)
		,.pll_locked_i  (pll_locked_i)
		,.cpu_rst_req_i (cpu_rst_req_i)
		,.swrst_cmd_i   (swrst_cmd_i)
		,.sys_rst_o     (sys_rst_o)
		,.ram_rst_o     (ram_rst_o)
		,.cold_rst_o    (cold_rst_o)
	);

	// SD card stays unpowered while the system is in reset
	assign sd_reset_o = sys_rst_o;

	activity_led u_activity_led (
		 .clk_4x_w   (clk_4x_w)
		,.rst_p      (rst_p)
		,.sd_di_i    (sd_di_i)
		,.sd_do_i    (sd_do_i)
		,.dram_err_i (dram_err_i)
		,.gpio_i     (gpio_i)
		,.gp_o       (gp_o)
	);

	dev_table u_dev_table (
		 .clk_4x_w     (clk_4x_w)
		,.rst_p        (rst_p)
		,.rd_stb_i     (rd_stb_i)
		,.rd_idx_i     (rd_idx_i)
		,.rd_vld_o     (rd_vld_o)
		,.rd_useintr_o (rd_useintr_o)
		,.rd_id_o      (rd_id_o)
		,.rd_int_src_o (rd_int_src_o)
	);

endmodule

// File: bench/board_ctrl_model.svh
`ifndef BOARD_CTRL_MODEL_SVH
`define BOARD_CTRL_MODEL_SVH

// Expected device table, one entry per slave index
localparam dev_id_t EXP_ID [DEV_CNT] = '{
	8'd4, 8'd7, 8'd6, 8'd3, 8'd5, 8'd1, 8'd0, 8'd0, 8'd10, 8'd0
};

localparam logic EXP_USEINTR [DEV_CNT] = '{
	1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0
};

// Model state, advanced once per rising edge
int       m_sys_cnt = 0;
int       m_ram_cnt = 0;
logic     m_pwroff  = 1'b0;
logic     m_act     = 1'b0;
int       m_act_cnt = 0;
logic     m_vld     = 1'b0;
dev_id_t  m_id      = '0;
logic     m_useintr = 1'b0;
int_src_t m_int_src = '0;

// Only the three interrupt users have a source line
function automatic int_src_t exp_int_src(input int idx);
	int_src_t src;
	src = '0;
	if (idx == int'(DEV_SDCARD)) begin
		src = INT_SRC_SDCARD;
	end else if (idx == int'(DEV_GPIO)) begin
		src = INT_SRC_GPIO;
	end else if (idx == int'(DEV_UART)) begin
		src = INT_SRC_UART;
	end
	return src;
endfunction

// Samples the inputs as the DUT sees them at this edge
task automatic model_step();
	logic warm;
	logic trig;
	int   idx;
	warm = (swrst_cmd == 2'b10);
	trig = ~sd_di | ~sd_do | dram_err;
	if (rst_p || cpu_rst_req || warm) begin
		m_sys_cnt = CNT_MAX;
	end else if (m_sys_cnt > 0) begin
		m_sys_cnt = m_sys_cnt - 1;
	end
	// Set has priority over the external reset
	if (swrst_cmd == 2'b01) begin
		m_pwroff = 1'b1;
	end else if (rst_p) begin
		m_pwroff = 1'b0;
	end
	if (rst_p) begin
		m_ram_cnt = CNT_MAX;
	end else if (pll_locked && (m_ram_cnt > 0)) begin
		m_ram_cnt = m_ram_cnt - 1;
	end
	if (rst_p) begin
		m_act     = 1'b0;
		m_act_cnt = 0;
	end else if (m_act_cnt > 0) begin
		m_act     = 1'b0;
		m_act_cnt = m_act_cnt - 1;
	end else begin
		m_act     = trig;
		m_act_cnt = trig ? ACT_MAX : 0;
	end
	m_vld = rst_p ? 1'b0 : rd_stb;
	if (rd_stb) begin
		idx = int'(rd_idx);
		if (idx >= DEV_CNT) begin
			idx = int'(DEV_INVALID);
		end
		m_id      = EXP_ID[idx];
		m_useintr = EXP_USEINTR[idx];
		m_int_src = exp_int_src(idx);
	end
endtask

function automatic logic model_sys_rst();
	return (m_sys_cnt != 0) || m_pwroff || !pll_locked;
endfunction

function automatic logic model_ram_rst();
	return (m_ram_cnt != 0);
endfunction

function automatic gpio_t model_gp();
	return gpio | gpio_t'(m_act);
endfunction

`endif

// File: bench/board_ctrl_tb.sv
module board_ctrl_tb
	import board_ctrl_pkg::*;
();

	localparam int RST_W    = 5;
	localparam int CNT_MAX  = (1 << RST_W) - 1;
	localparam int ACT_MAX  = (1 << ACT_CNT_W) - 1;
	localparam int RST_HOLD = 16;
	localparam int CLK_PER  = 20;

	// Cycle budget of each phase
	localparam int PH1_CYC   = 50;
	localparam int PH2_CYC   = 250;
	localparam int PH3_CYC   = 150;
	localparam int PH4_CYC   = 250;
	localparam int PH5_CYC   = 300;
	localparam int PH6_CYC   = 300;
	localparam int TOTAL_CYC = RST_HOLD + PH1_CYC + PH2_CYC + PH3_CYC
		+ PH4_CYC + PH5_CYC + PH6_CYC;
	localparam int WDOG_TIME = 2 * TOTAL_CYC * CLK_PER;

	logic       clk_4x_w;
	logic       rst_p;
	logic       pll_locked;
	logic       cpu_rst_req;
	swrst_cmd_t swrst_cmd;
	logic       sd_di;
	logic       sd_do;
	logic       dram_err;
	gpio_t      gpio;
	logic       rd_stb;
	dev_idx_t   rd_idx;

	logic       sys_rst;
	logic       ram_rst;
	logic       cold_rst;
	logic       sd_reset;
	gpio_t      gp;
	logic       rd_vld;
	logic       rd_useintr;
	dev_id_t    rd_id;
	int_src_t   rd_int_src;

	integer seed;
	int     rst_errs = 0;
	int     act_errs = 0;
	int     tbl_errs = 0;

	`include "board_ctrl_model.svh"

	board_ctrl_top #(
		.RST_CNT_W (RST_W)
	) uut (
		 .clk_4x_w      (clk_4x_w)
		,.rst_p         (rst_p)
		,.pll_locked_i  (pll_locked)
		,.cpu_rst_req_i (cpu_rst_req)
		,.swrst_cmd_i   (swrst_cmd)
		,.sd_di_i       (sd_di)
		,.sd_do_i       (sd_do)
		,.dram_err_i    (dram_err)
		,.gpio_i        (gpio)
		,.rd_stb_i      (rd_stb)
		,.rd_idx_i      (rd_idx)
		,.sys_rst_o     (sys_rst)
		,.ram_rst_o     (ram_rst)
		,.cold_rst_o    (cold_rst)
		,.sd_reset_o    (sd_reset)
		,.gp_o          (gp)
		,.rd_vld_o      (rd_vld)
		,.rd_useintr_o  (rd_useintr)
		,.rd_id_o       (rd_id)
		,.rd_int_src_o  (rd_int_src)
	);

	initial begin
		clk_4x_w = 1'b0;
		forever #(CLK_PER / 2) clk_4x_w = ~clk_4x_w;
	end

	// Model advances on the rising edge and the outputs are compared on the falling edge
	always @(posedge clk_4x_w) model_step();
	always @(negedge clk_4x_w) check_outputs();

	task automatic check_outputs();
		logic  exp_sys;
		gpio_t exp_gp;
		exp_sys = model_sys_rst();
		exp_gp  = model_gp();
		assert (sys_rst === exp_sys) else begin
			$display("ERROR %0t: sys_rst_o is %b, expected %b", $time, sys_rst, exp_sys);
			rst_errs++;
		end
		assert (sd_reset === exp_sys) else begin
			$display("ERROR %0t: sd_reset_o is %b, expected %b", $time, sd_reset, exp_sys);
			rst_errs++;
		end
		assert (ram_rst === model_ram_rst()) else begin
			$display("ERROR %0t: ram_rst_o is %b, expected %b", $time, ram_rst,
				model_ram_rst());
			rst_errs++;
		end
		assert (cold_rst === (swrst_cmd == 2'b11)) else begin
			$display("ERROR %0t: cold_rst_o is %b with command %b", $time, cold_rst, swrst_cmd);
			rst_errs++;
		end
		assert (gp === exp_gp) else begin
			$display("ERROR %0t: gp_o is %h, expected %h", $time, gp, exp_gp);
			act_errs++;
		end
		assert (rd_vld === m_vld) else begin
			$display("ERROR %0t: rd_vld_o is %b, expected %b", $time, rd_vld, m_vld);
			tbl_errs++;
		end
		if (m_vld) begin
			assert ((rd_id === m_id) && (rd_useintr === m_useintr)
				&& (rd_int_src === m_int_src)) else begin
				$display("ERROR %0t: reply %0d/%b/%0d, expected %0d/%b/%0d", $time, rd_id,
					rd_useintr, rd_int_src, m_id, m_useintr, m_int_src);
				tbl_errs++;
			end
		end
	endtask

	task automatic drive_idle();
		pll_locked  <= 1'b1;
		cpu_rst_req <= 1'b0;
		swrst_cmd   <= 2'b00;
		sd_di       <= 1'b1;
		sd_do       <= 1'b1;
		dram_err    <= 1'b0;
		gpio        <= '0;
		rd_stb      <= 1'b0;
		rd_idx      <= '0;
	endtask

	task automatic run_idle(input int n);
		repeat (n) begin
			@(posedge clk_4x_w);
			drive_idle();
		end
	endtask

	task automatic pulse_reset(input int n);
		@(posedge clk_4x_w);
		drive_idle();
		rst_p <= 1'b1;
		repeat (n) @(posedge clk_4x_w);
		rst_p <= 1'b0;
	endtask

	// Counts the cycles that sys_rst_o stays high after the last reload
	task automatic measure_reset_length();
		int hi_cnt;
		hi_cnt = 0;
		@(negedge clk_4x_w);
		while ((sys_rst === 1'b1) && (hi_cnt <= CNT_MAX)) begin
			hi_cnt++;
			@(negedge clk_4x_w);
		end
		assert (hi_cnt == CNT_MAX) else begin
			$display("ERROR %0t: reset held %0d cycles, expected %0d", $time, hi_cnt, CNT_MAX);
			rst_errs++;
		end
	endtask

	task automatic random_resets(input int n);
		logic [31:0] rnd;
		repeat (n) begin
			@(posedge clk_4x_w);
			rnd = $random(seed);
			case (rnd[4:0])
				5'd0: swrst_cmd <= 2'b10;
				5'd1, 5'd2: swrst_cmd <= 2'b11;
				default: swrst_cmd <= 2'b00;
			endcase
			cpu_rst_req <= (rnd[9:5] == 5'd0);
		end
	endtask

	// Sparse reload requests let the counter run out while the latch holds
	task automatic power_off_hold(input int n);
		logic [31:0] rnd;
		@(posedge clk_4x_w);
		swrst_cmd <= 2'b01;
		@(posedge clk_4x_w);
		swrst_cmd <= 2'b00;
		repeat (n) begin
			@(posedge clk_4x_w);
			rnd = $random(seed);
			swrst_cmd   <= (rnd[5:0] == 6'd0) ? 2'b10 : 2'b00;
			cpu_rst_req <= (rnd[11:6] == 6'd0);
			@(negedge clk_4x_w);
			assert (sys_rst === 1'b1) else begin
				$display("ERROR %0t: sys_rst_o released during power-off", $time);
				rst_errs++;
			end
		end
	endtask

	task automatic pll_glitches(input int n);
		logic [31:0] rnd;
		repeat (n) begin
			@(posedge clk_4x_w);
			rnd = $random(seed);
			if (rnd[2:0] == 3'd0) begin
				pll_locked <= ~pll_locked;
			end
			swrst_cmd <= (rnd[6:3] == 4'd0) ? 2'b10 : 2'b00;
		end
	endtask

	task automatic random_activity(input int n);
		logic [31:0] rnd;
		repeat (n) begin
			@(posedge clk_4x_w);
			rnd = $random(seed);
			sd_di    <= (rnd[1:0] != 2'b00);
			sd_do    <= (rnd[3:2] != 2'b00);
			dram_err <= (rnd[7:4] == 4'd0);
			gpio     <= rnd[15:8];
		end
	endtask

	task automatic random_lookups(input int n);
		logic [31:0] rnd;
		repeat (n) begin
			@(posedge clk_4x_w);
			rnd = $random(seed);
			rd_stb <= (rnd[1:0] != 2'b00);
			rd_idx <= rnd[5:2];
		end
	endtask

	initial begin
		#(WDOG_TIME);
		$display("Watchdog timeout: the run did not finish within %0d time units", WDOG_TIME);
		$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		seed        = 32'he79c;
		rst_p       = 1'b1;
		pll_locked  = 1'b1;
		cpu_rst_req = 1'b0;
		swrst_cmd   = 2'b00;
		sd_di       = 1'b1;
		sd_do       = 1'b1;
		dram_err    = 1'b0;
		gpio        = '0;
		rd_stb      = 1'b0;
		rd_idx      = '0;
		repeat (RST_HOLD) @(posedge clk_4x_w);
		rst_p <= 1'b0;

		measure_reset_length();
		run_idle(8);

		random_resets(PH2_CYC - 50);
		run_idle(CNT_MAX + 8);

		power_off_hold(PH3_CYC - 60);
		pulse_reset(2);
		run_idle(CNT_MAX + 8);
		@(negedge clk_4x_w);
		assert (sys_rst === 1'b0) else begin
			$display("ERROR %0t: sys_rst_o still high after external reset", $time);
			rst_errs++;
		end

		pulse_reset(2);
		pll_glitches(PH4_CYC - 50);
		run_idle(CNT_MAX + 8);

		random_activity(PH5_CYC);
		run_idle(4);
		random_lookups(PH6_CYC);
		run_idle(4);

		$display("Error count: reset %0d, activity %0d, table %0d", rst_errs, act_errs,
			tbl_errs);
		if ((rst_errs + act_errs + tbl_errs) == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// File: board_ctrl.f
+incdir+bench
hw/board_ctrl_pkg.sv
hw/rst_seq.sv
hw/activity_led.sv
hw/dev_table.sv
hw/board_ctrl_top.sv
bench/board_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= board_ctrl_tb
RTL_TOP   ?= board_ctrl_top
FLIST     ?= board_ctrl.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

RTL_FILES = hw/board_ctrl_pkg.sv \
            hw/rst_seq.sv \
            hw/activity_led.sv \
            hw/dev_table.sv \
            hw/board_ctrl_top.sv

PASS_MSG = Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Result: test passed"; \
	else \
		echo "Result: test failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
